// File: Makefile
# Verilator build and run for the CPU control unit testbench

SIM      ?= verilator
TOP      ?= cpuControlTb
SEED     ?= 68
TIMEOUT  ?= 20000
FILELIST ?= build.f
OBJDIR   ?= obj_dir
SIMFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GseedInit=$(SEED) -GtimeoutCycles=$(TIMEOUT) --Mdir $(OBJDIR)

# A $fatal or failed assertion gives a nonzero exit status
run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(SIM) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// File: build.f
+incdir+include
source/isaPkg.sv
source/ctrlPkg.sv
source/opcodeDecoder.sv
source/stepSequencer.sv
source/controlStrobes.sv
source/cpuControl.sv
dv/cpuControl_asserts.sv
dv/cpuControlTb.sv

// File: dv/cpuControlTb.sv
/* CPU control unit testbench */

`timescale 1ns/1ns
`include "cpuControl_cfg.svh"

module cpuControlTb #(
    parameter int seedInit = 68,
    parameter int timeoutCycles = 20000
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int runCycles = 3000;

    // Bit positions in the packed strobe vector
    localparam int pRun = 21;
    localparam int pRead = 20;
    localparam int pWrite = 19;
    localparam int pBaOut = 18;
    localparam int pRegIn = 17;
    localparam int pRegOut = 16;
    localparam int pGra = 15;
    localparam int pGrb = 14;
    localparam int pGrc = 13;
    localparam int pMarIn = 12;
    localparam int pMdrIn = 11;
    localparam int pYIn = 10;
    localparam int pZIn = 9;
    localparam int pPcIn = 8;
    localparam int pPcOut = 7;
    localparam int pIrIn = 6;
    localparam int pIncPc = 5;
    localparam int pInPortOut = 4;
    localparam int pOutPortIn = 3;
    localparam int pZLowOut = 2;
    localparam int pMdrOut = 1;
    localparam int pCOut = 0;

    // Opcodes that decode to a class other than noOp
    localparam opcode_e keptOps [20] = '{
        opLd, opLdi, opSt, opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
        opRor, opRol, opAddi, opAndi, opOri, opNeg, opNot, opJr, opIn, opOut
    };

    logic clk = 1'b0;
    logic reset;
    logic stop;
    logic [`INSTR_WIDTH-1:0] IRdata;
    logic run;
    logic read;
    logic write;
    logic baOut;
    logic regIn;
    logic regOut;
    logic gra;
    logic grb;
    logic grc;
    logic marIn;
    logic mdrIn;
    logic yIn;
    logic zIn;
    logic pcIn;
    logic pcOut;
    logic irIn;
    logic incPc;
    logic inPortOut;
    logic outPortIn;
    logic zLowOut;
    logic mdrOut;
    logic cOut;
    aluOp_e aluOpcode;
    logic [21:0] actStrobes;

    int seed;
    int stopLeft;
    int fetchVisits;
    int haltCount;

    // Cycle model state
    phase_e mPhase;
    int mStep;
    instrClass_e mClass;
    aluOp_e mAluOp;
    int mLast;
    phase_e savedPhase;
    int savedStep;

    cpuControl dut (.*);

    assign actStrobes = {run, read, write, baOut, regIn, regOut, gra, grb, grc, marIn, mdrIn,
                         yIn, zIn, pcIn, pcOut, irIn, incPc, inPortOut, outPortIn, zLowOut,
                         mdrOut, cOut};

    always #5 clk = ~clk;

    function automatic instrClass_e classOf(logic [4:0] op);
        case (op)
            opAdd, opSub, opAnd, opOr, opShl, opShr, opShra, opRol, opRor: return aluReg;
            opNeg, opNot: return aluUnary;
            opAddi, opAndi, opOri: return aluImm;
            opLd: return load;
            opLdi: return loadImm;
            opSt: return store;
            opJr: return jumpReg;
            opIn: return portIn;
            opOut: return portOut;
            default: return noOp;
        endcase
    endfunction

    function automatic aluOp_e aluOpOf(logic [4:0] op);
        case (op)
            opAdd, opAddi, opLd, opLdi, opSt: return aluAdd;
            opSub: return aluSub;
            opAnd, opAndi: return aluAnd;
            opOr, opOri: return aluOr;
            opShl: return aluShl;
            opShr: return aluShr;
            opShra: return aluShra;
            opRol: return aluRol;
            opRor: return aluRor;
            opNeg: return aluNeg;
            opNot: return aluNot;
            default: return aluNop;
        endcase
    endfunction

    function automatic int lastStepOf(instrClass_e cls);
        case (cls)
            aluReg, aluUnary, aluImm, loadImm: return 3;
            load: return 5;
            store: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic [21:0] expectedStrobes(phase_e ph, int st, instrClass_e cls);
        logic [21:0] s;
        s = '0;
        s[pRun] = (ph != halted);
        if (ph == fetch0) begin
            s[pPcOut] = 1'b1;
            s[pMarIn] = 1'b1;
            s[pZIn] = 1'b1;
            s[pIncPc] = 1'b1;
        end else if (ph == fetch1) begin
            s[pZLowOut] = 1'b1;
            s[pPcIn] = 1'b1;
            s[pRead] = 1'b1;
            s[pMdrIn] = 1'b1;
        end else if (ph == fetch2) begin
            s[pMdrOut] = 1'b1;
            s[pIrIn] = 1'b1;
        end else if (ph == execute) begin
            if (cls == aluReg || cls == aluUnary || cls == aluImm) begin
                if (st == 1) begin
                    s[pGrb] = 1'b1;
                    s[pYIn] = 1'b1;
                end else if (st == 2) begin
                    s[pZIn] = 1'b1;
                    s[pGrc] = (cls == aluReg);
                    s[pRegOut] = (cls == aluReg);
                    s[pCOut] = (cls == aluImm);
                end else if (st == 3) begin
                    s[pZLowOut] = 1'b1;
                    s[pGra] = 1'b1;
                    s[pRegIn] = 1'b1;
                end
            end else if (cls == load || cls == loadImm || cls == store) begin
                if (st == 1) begin
                    s[pGrb] = 1'b1;
                    s[pBaOut] = 1'b1;
                    s[pYIn] = 1'b1;
                end else if (st == 2) begin
                    s[pZIn] = 1'b1;
                    s[pCOut] = 1'b1;
                end else if (st == 3) begin
                    s[pZLowOut] = 1'b1;
                    if (cls == loadImm) begin
                        s[pGra] = 1'b1;
                        s[pRegIn] = 1'b1;
                    end else begin
                        s[pMarIn] = 1'b1;
                    end
                end else if (st == 4 && cls == load) begin
                    s[pRead] = 1'b1;
                    s[pMdrIn] = 1'b1;
                end else if (st == 4 && cls == store) begin
                    s[pWrite] = 1'b1;
                    s[pMdrIn] = 1'b1;
                    s[pRegOut] = 1'b1;
                    s[pGra] = 1'b1;
                end else if (st == 5 && cls == load) begin
                    s[pMdrOut] = 1'b1;
                    s[pGra] = 1'b1;
                    s[pRegIn] = 1'b1;
                end
            end else if (cls == jumpReg) begin
                s[pGra] = 1'b1;
                s[pRegOut] = 1'b1;
                s[pPcIn] = 1'b1;
            end else if (cls == portIn) begin
                s[pInPortOut] = 1'b1;
                s[pGra] = 1'b1;
                s[pRegIn] = 1'b1;
            end else if (cls == portOut) begin
                s[pOutPortIn] = 1'b1;
                s[pGra] = 1'b1;
                s[pRegOut] = 1'b1;
            end
        end
        return s;
    endfunction

    function automatic aluOp_e expectedAluOpcode();
        if (mPhase != execute || mStep != 2) begin
            return aluNop;
        end
        if (mClass == aluReg || mClass == aluUnary || mClass == aluImm) begin
            return mAluOp;
        end
        if (mClass == load || mClass == loadImm || mClass == store) begin
            return aluAdd;
        end
        return aluNop;
    endfunction

    function automatic string testName();
        if (mPhase == execute) begin
            return $sformatf("%s step %0d", mClass.name(), mStep);
        end
        return mPhase.name();
    endfunction

    function automatic logic [`INSTR_WIDTH-1:0] randomInstr();
        logic [`INSTR_WIDTH-1:0] w;
        w = $random(seed);
        if ($random(seed) & 1) begin
            w[`OPCODE_MSB:`OPCODE_LSB] = keptOps[$unsigned($random(seed)) % 20];
        end
        return w;
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    task automatic reportMismatch(string name, logic [21:0] expected, logic [21:0] actual);
        $display("CHECK FAILED: %s expected %b actual %b", name, expected, actual);
        $display("Verification failed");
        $fatal(1, "output differs from the cycle model");
    endtask

    task automatic checkOutputs();
        logic [21:0] expStrobes;
        aluOp_e expAlu;
        expStrobes = expectedStrobes(mPhase, mStep, mClass);
        expAlu = expectedAluOpcode();
        assert (actStrobes === expStrobes)
            else reportMismatch({testName(), " strobes"}, expStrobes, actStrobes);
        assert (aluOpcode === expAlu)
            else reportMismatch({testName(), " aluOpcode"}, 22'(expAlu), 22'(aluOpcode));
    endtask

    // One clock edge of the model, using inputs held before the edge
    task automatic advanceModel(logic stopIn, logic [`INSTR_WIDTH-1:0] instrIn);
        phase_e nPhase;
        int nStep;
        nStep = 0;
        case (mPhase)
            fetch0: nPhase = fetch1;
            fetch1: nPhase = fetch2;
            fetch2: begin
                nPhase = execute;
                nStep = 1;
            end
            execute: begin
                nPhase = (mStep == mLast) ? fetch0 : execute;
                nStep = (mStep == mLast) ? 0 : mStep + 1;
            end
            default: begin
                nPhase = savedPhase;
                nStep = savedStep;
            end
        endcase
        if (mPhase == fetch2) begin
            mClass = classOf(instrIn[`OPCODE_MSB:`OPCODE_LSB]);
            mAluOp = aluOpOf(instrIn[`OPCODE_MSB:`OPCODE_LSB]);
            mLast = lastStepOf(mClass);
        end
        if (stopIn) begin
            if (mPhase != halted) begin
                savedPhase = nPhase;
                savedStep = nStep;
                haltCount++;
            end
            mPhase = halted;
        end else begin
            mPhase = nPhase;
            mStep = nStep;
            if (nPhase == fetch0) begin
                fetchVisits++;
            end
        end
    endtask

    task automatic driveStimulus();
        if (stopLeft > 0) begin
            stop <= 1'b1;
            stopLeft--;
        end else if (($unsigned($random(seed)) % 12) == 0) begin
            stop <= 1'b1;
            stopLeft = $unsigned($random(seed)) % 4;
        end else begin
            stop <= 1'b0;
        end
        IRdata <= randomInstr();
    endtask

    task automatic runCycle();
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        advanceModel(stop, IRdata);
        driveStimulus();
    endtask

    task automatic waitForCoverage(int minFetch, int minHalts);
        int waited;
        waited = 0;
        while ((fetchVisits < minFetch || haltCount < minHalts) && waited < timeoutCycles) begin
            runCycle();
            waited++;
        end
        if (fetchVisits < minFetch || haltCount < minHalts) begin
            abortRun("Timed out waiting for enough fetch0 visits and halts");
        end
    endtask

    initial begin
        seed = seedInit;
        reset = 1'b1;
        stop = 1'b0;
        IRdata = '0;
        stopLeft = 0;
        fetchVisits = 0;
        haltCount = 0;
        mPhase = halted;
        mStep = 0;
        mClass = noOp;
        mAluOp = aluNop;
        mLast = 1;
        savedPhase = fetch0;
        savedStep = 0;

        // Model holds in reset state while reset is high
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkOutputs();
            @(posedge clk);
        end
        reset <= 1'b0;
        IRdata <= randomInstr();

        for (int cycle = 0; cycle < runCycles; cycle++) begin
            runCycle();
        end
        waitForCoverage(200, 50);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: dv/cpuControl_asserts.sv
/* Control unit strobe assertions */

`timescale 1ns/1ns

module cpuControlAsserts (
    input logic            clk,
    input logic            reset,
    input logic            run,
    input logic            read,
    input logic            write,
    input logic            baOut,
    input logic            regIn,
    input logic            regOut,
    input logic            gra,
    input logic            grb,
    input logic            grc,
    input logic            marIn,
    input logic            mdrIn,
    input logic            yIn,
    input logic            zIn,
    input logic            pcIn,
    input logic            pcOut,
    input logic            irIn,
    input logic            incPc,
    input logic            inPortOut,
    input logic            outPortIn,
    input logic            zLowOut,
    input logic            mdrOut,
    input logic            cOut,
    input ctrlPkg::aluOp_e aluOpcode
);
    import ctrlPkg::*;

    logic [20:0] strobes;

    assign strobes = {read, write, baOut, regIn, regOut, gra, grb, grc, marIn, mdrIn, yIn,
                      zIn, pcIn, pcOut, irIn, incPc, inPortOut, outPortIn, zLowOut, mdrOut,
                      cOut};

    // Memory bus is either read or written
    readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write are high in the same cycle");

    haltedQuiet: assert property (@(posedge clk) disable iff (reset)
        !run |-> (strobes == '0))
        else $error("a strobe is high while run is low");

    // ALU operation only matters when Z captures
    aluOnlyWithZ: assert property (@(posedge clk) disable iff (reset)
        (aluOpcode != aluNop) |-> zIn)
        else $error("aluOpcode is not nop while zIn is low");

endmodule

bind cpuControl cpuControlAsserts checks (
    .clk(clk), .reset(reset), .run(run), .read(read), .write(write), .baOut(baOut),
    .regIn(regIn), .regOut(regOut), .gra(gra), .grb(grb), .grc(grc), .marIn(marIn),
    .mdrIn(mdrIn), .yIn(yIn), .zIn(zIn), .pcIn(pcIn), .pcOut(pcOut), .irIn(irIn),
    .incPc(incPc), .inPortOut(inPortOut), .outPortIn(outPortIn), .zLowOut(zLowOut),
    .mdrOut(mdrOut), .cOut(cOut), .aluOpcode(aluOpcode)
);

// File: include/cpuControl_cfg.svh
/* CPU control unit configuration */

`ifndef CPU_CONTROL_CFG_SVH
`define CPU_CONTROL_CFG_SVH

// Instruction word and opcode field
`define INSTR_WIDTH 32
`define OPCODE_MSB 31
`define OPCODE_LSB 27

`define ALU_OP_WIDTH 5

// Up to five execute steps
`define STEP_WIDTH 3

`endif

// File: source/controlStrobes.sv
/* Datapath strobe decoder */

`timescale 1ns/1ns
`include "cpuControl_cfg.svh"

module controlStrobes (
    input  ctrlPkg::phase_e         phase,
    input  logic [`STEP_WIDTH-1:0]  step,
    input  isaPkg::instrClass_e     instrClass,
    input  ctrlPkg::aluOp_e         aluOp,
    output logic                    run,
    output logic                    read,
    output logic                    write,
    output logic                    baOut,
    output logic                    regIn,
    output logic                    regOut,
    output logic                    gra,
    output logic                    grb,
    output logic                    grc,
    output logic                    marIn,
    output logic                    mdrIn,
    output logic                    yIn,
    output logic                    zIn,
    output logic                    pcIn,
    output logic                    pcOut,
    output logic                    irIn,
    output logic                    incPc,
    output logic                    inPortOut,
    output logic                    outPortIn,
    output logic                    zLowOut,
    output logic                    mdrOut,
    output logic                    cOut,
    output ctrlPkg::aluOp_e         aluOpcode
);
    import isaPkg::*;
    import ctrlPkg::*;

    assign run = (phase != halted);

    always_comb begin
        read = 1'b0;
        write = 1'b0;
        baOut = 1'b0;
        regIn = 1'b0;
        regOut = 1'b0;
        gra = 1'b0;
        grb = 1'b0;
        grc = 1'b0;
        marIn = 1'b0;
        mdrIn = 1'b0;
        yIn = 1'b0;
        zIn = 1'b0;
        pcIn = 1'b0;
        pcOut = 1'b0;
        irIn = 1'b0;
        incPc = 1'b0;
        inPortOut = 1'b0;
        outPortIn = 1'b0;
        zLowOut = 1'b0;
        mdrOut = 1'b0;
        cOut = 1'b0;
        aluOpcode = aluNop;

        case (phase)
            fetch0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                zIn = 1'b1;
                incPc = 1'b1;
            end
            fetch1: begin
                zLowOut = 1'b1;
                pcIn = 1'b1;
                read = 1'b1;
                mdrIn = 1'b1;
            end
            fetch2: begin
                mdrOut = 1'b1;
                irIn = 1'b1;
            end
            execute: begin
                case (instrClass)
                    aluReg, aluUnary, aluImm: begin
                        case (step)
                            `STEP_WIDTH'(1): begin
                                grb = 1'b1;
                                yIn = 1'b1;
                            end
                            `STEP_WIDTH'(2): begin
                                zIn = 1'b1;
                                aluOpcode = aluOp;
                                grc = (instrClass == aluReg);
                                regOut = (instrClass == aluReg);
                                cOut = (instrClass == aluImm);
                            end
                            `STEP_WIDTH'(3): begin
                                zLowOut = 1'b1;
                                gra = 1'b1;
                                regIn = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    load, loadImm, store: begin
                        case (step)
                            // Base plus offset into Y then Z
                            `STEP_WIDTH'(1): begin
                                grb = 1'b1;
                                baOut = 1'b1;
                                yIn = 1'b1;
                            end
                            `STEP_WIDTH'(2): begin
                                zIn = 1'b1;
                                cOut = 1'b1;
                                aluOpcode = aluAdd;
                            end
                            `STEP_WIDTH'(3): begin
                                zLowOut = 1'b1;
                                marIn = (instrClass != loadImm);
                                gra = (instrClass == loadImm);
                                regIn = (instrClass == loadImm);
                            end
                            `STEP_WIDTH'(4): begin
                                mdrIn = 1'b1;
                                read = (instrClass == load);
                                write = (instrClass == store);
                                regOut = (instrClass == store);
                                gra = (instrClass == store);
                            end
                            `STEP_WIDTH'(5): begin
                                mdrOut = 1'b1;
                                gra = 1'b1;
                                regIn = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    jumpReg: begin
                        gra = 1'b1;
                        regOut = 1'b1;
                        pcIn = 1'b1;
                    end
                    portIn: begin
                        inPortOut = 1'b1;
                        gra = 1'b1;
                        regIn = 1'b1;
                    end
                    portOut: begin
                        outPortIn = 1'b1;
                        gra = 1'b1;
                        regOut = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: source/cpuControl.sv
/* CPU control unit */

`timescale 1ns/1ns
`include "cpuControl_cfg.svh"

module cpuControl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stop,
    input  logic [`INSTR_WIDTH-1:0] IRdata,
    output logic                    run,
    output logic                    read,
    output logic                    write,
    output logic                    baOut,
    output logic                    regIn,
    output logic                    regOut,
    output logic                    gra,
    output logic                    grb,
    output logic                    grc,
    output logic                    marIn,
    output logic                    mdrIn,
    output logic                    yIn,
    output logic                    zIn,
    output logic                    pcIn,
    output logic                    pcOut,
    output logic                    irIn,
    output logic                    incPc,
    output logic                    inPortOut,
    output logic                    outPortIn,
    output logic                    zLowOut,
    output logic                    mdrOut,
    output logic                    cOut,
    output ctrlPkg::aluOp_e         aluOpcode
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Decode of the word now in IRdata
    instrClass_e            decClass;
    aluOp_e                 decAluOp;
    logic [`STEP_WIDTH-1:0] decLastStep;

    phase_e                 phase;
    logic [`STEP_WIDTH-1:0] step;
    instrClass_e            instrClass;
    aluOp_e                 aluOp;

    opcodeDecoder decoder (
        .instr      (IRdata),
        .instrClass (decClass),
        .aluOp      (decAluOp),
        .lastStep   (decLastStep)
    );

    stepSequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .stop         (stop),
        .nextClass    (decClass),
        .nextAluOp    (decAluOp),
        .nextLastStep (decLastStep),
        .phase        (phase),
        .step         (step),
        .instrClass   (instrClass),
        .aluOp        (aluOp)
    );

    controlStrobes strobes (
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .run        (run),
        .read       (read),
        .write      (write),
        .baOut      (baOut),
        .regIn      (regIn),
        .regOut     (regOut),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .pcIn       (pcIn),
        .pcOut      (pcOut),
        .irIn       (irIn),
        .incPc      (incPc),
        .inPortOut  (inPortOut),
        .outPortIn  (outPortIn),
        .zLowOut    (zLowOut),
        .mdrOut     (mdrOut),
        .cOut       (cOut),
        .aluOpcode  (aluOpcode)
    );

endmodule

// File: source/ctrlPkg.sv
/* Control unit types */

`include "cpuControl_cfg.svh"

package ctrlPkg;

    // Sequencer phase
    typedef enum logic [2:0] {
        fetch0,
        fetch1,
        fetch2,
        execute,
        halted
    } phase_e;

    // ALU operation codes as seen by the datapath
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        aluNop  = 0,
        aluAdd  = 1,
        aluSub  = 2,
        aluShr  = 5,
        aluShl  = 6,
        aluShra = 7,
        aluRor  = 8,
        aluRol  = 9,
        aluAnd  = 10,
        aluOr   = 11,
        aluNeg  = 12,
        aluNot  = 15
    } aluOp_e;

endpackage

// File: source/isaPkg.sv
/* Instruction set types */

`include "cpuControl_cfg.svh"

package isaPkg;

    // Opcode field values of the supported instructions
    typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
        opLd   = 0,
        opLdi  = 1,
        opSt   = 2,
        opAdd  = 3,
        opSub  = 4,
        opAnd  = 5,
        opOr   = 6,
        opShr  = 7,
        opShra = 8,
        opShl  = 9,
        opRor  = 10,
        opRol  = 11,
        opAddi = 12,
        opAndi = 13,
        opOri  = 14,
        opNeg  = 17,
        opNot  = 18,
        opJr   = 20,
        opIn   = 22,
        opOut  = 23
    } opcode_e;

    // Instructions grouped by execute sequence
    typedef enum logic [3:0] {
        aluReg,
        aluUnary,
        aluImm,
        load,
        loadImm,
        store,
        jumpReg,
        portIn,
        portOut,
        noOp
    } instrClass_e;

endpackage

// File: source/opcodeDecoder.sv
/* Opcode decoder */

`timescale 1ns/1ns
`include "cpuControl_cfg.svh"

module opcodeDecoder (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output isaPkg::instrClass_e     instrClass,
    output ctrlPkg::aluOp_e         aluOp,
    output logic [`STEP_WIDTH-1:0]  lastStep
);
    import isaPkg::*;
    import ctrlPkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[`OPCODE_MSB:`OPCODE_LSB]);

    always_comb begin
        instrClass = noOp;
        aluOp = aluNop;
        case (opcode)
            opAdd:  begin instrClass = aluReg;   aluOp = aluAdd;  end
            opSub:  begin instrClass = aluReg;   aluOp = aluSub;  end
            opAnd:  begin instrClass = aluReg;   aluOp = aluAnd;  end
            opOr:   begin instrClass = aluReg;   aluOp = aluOr;   end
            opShl:  begin instrClass = aluReg;   aluOp = aluShl;  end
            opShr:  begin instrClass = aluReg;   aluOp = aluShr;  end
            opShra: begin instrClass = aluReg;   aluOp = aluShra; end
            opRol:  begin instrClass = aluReg;   aluOp = aluRol;  end
            opRor:  begin instrClass = aluReg;   aluOp = aluRor;  end
            opNeg:  begin instrClass = aluUnary; aluOp = aluNeg;  end
            opNot:  begin instrClass = aluUnary; aluOp = aluNot;  end
            opAddi: begin instrClass = aluImm;   aluOp = aluAdd;  end
            opAndi: begin instrClass = aluImm;   aluOp = aluAnd;  end
            opOri:  begin instrClass = aluImm;   aluOp = aluOr;   end
            // Address and immediate sums use the adder
            opLd:   begin instrClass = load;     aluOp = aluAdd;  end
            opLdi:  begin instrClass = loadImm;  aluOp = aluAdd;  end
            opSt:   begin instrClass = store;    aluOp = aluAdd;  end
            opJr:   instrClass = jumpReg;
            opIn:   instrClass = portIn;
            opOut:  instrClass = portOut;
            default: instrClass = noOp;
        endcase
    end

    // Final execute step per class
    always_comb begin
        case (instrClass)
            aluReg, aluUnary, aluImm, loadImm: lastStep = `STEP_WIDTH'(3);
            load:    lastStep = `STEP_WIDTH'(5);
            store:   lastStep = `STEP_WIDTH'(4);
            default: lastStep = `STEP_WIDTH'(1);
        endcase
    end

endmodule

// File: source/stepSequencer.sv
/* Control step sequencer */

`timescale 1ns/1ns
`include "cpuControl_cfg.svh"

module stepSequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stop,
    input  isaPkg::instrClass_e     nextClass,
    input  ctrlPkg::aluOp_e         nextAluOp,
    input  logic [`STEP_WIDTH-1:0]  nextLastStep,
    output ctrlPkg::phase_e         phase,
    output logic [`STEP_WIDTH-1:0]  step,
    output isaPkg::instrClass_e     instrClass,
    output ctrlPkg::aluOp_e         aluOp
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [`STEP_WIDTH-1:0] lastStep;
    phase_e                 savedPhase;
    logic [`STEP_WIDTH-1:0] savedStep;

    // State that follows the present one when stop is low
    phase_e                 advPhase;
    logic [`STEP_WIDTH-1:0] advStep;

    always_comb begin
        advPhase = phase;
        advStep = step;
        case (phase)
            fetch0: begin
                advPhase = fetch1;
                advStep = '0;
            end
            fetch1: begin
                advPhase = fetch2;
                advStep = '0;
            end
            fetch2: begin
                advPhase = execute;
                advStep = `STEP_WIDTH'(1);
            end
            execute: begin
                if (step == lastStep) begin
                    advPhase = fetch0;
                    advStep = '0;
                end else begin
                    advStep = step + `STEP_WIDTH'(1);
                end
            end
            halted: begin
                advPhase = savedPhase;
                advStep = savedStep;
            end
            default: begin
                advPhase = fetch0;
                advStep = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= halted;
            step <= '0;
            savedPhase <= fetch0;
            savedStep <= '0;
        end else if (stop) begin
            phase <= halted;
            // Only the first stop cycle records where to pick up
            if (phase != halted) begin
                savedPhase <= advPhase;
                savedStep <= advStep;
            end
        end else begin
            phase <= advPhase;
            step <= advStep;
        end
    end

    // Decode is taken on the edge leaving fetch2, stopped or not
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrClass <= noOp;
            aluOp <= aluNop;
            lastStep <= `STEP_WIDTH'(1);
        end else if (phase == fetch2) begin
            instrClass <= nextClass;
            aluOp <= nextAluOp;
            lastStep <= nextLastStep;
        end
    end

endmodule
